/* logic/lsu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared widths, types and codes of the load-store unit
// modules import it in their body and use scoped names in port lists
//////////////////////////////////////////////////////////////////////
`default_nettype none

package lsu_pkg;

  localparam int unsigned LSU_XLEN   = 32;           // address and data width
  localparam int unsigned LSU_NBYTES = LSU_XLEN / 8; // byte lanes per word

  typedef logic [LSU_XLEN-1:0]   lsu_word_t;   // address or data word
  typedef logic [LSU_NBYTES-1:0] lsu_be_t;     // one enable per lane
  typedef logic [1:0]            lsu_offset_t; // byte offset inside a word

  // access size, both byte codes are legal
  typedef enum logic [1:0] {
    LSU_SIZE_WORD  = 2'b00,
    LSU_SIZE_HALF  = 2'b01,
    LSU_SIZE_BYTE  = 2'b10,
    LSU_SIZE_BYTE2 = 2'b11
  } lsu_size_e;

  // fill of the upper bits on loads
  typedef enum logic [1:0] {
    LSU_EXT_ZERO  = 2'b00,
    LSU_EXT_SIGN  = 2'b01,
    LSU_EXT_ONE   = 2'b10,
    LSU_EXT_SIGN2 = 2'b11
  } lsu_ext_e;

  // attributes of the access in flight, 7 bits
  typedef struct packed {
    lsu_size_e   size;
    lsu_ext_e    ext;
    lsu_offset_t offset; // low address bits at grant
    logic        we;     // store, no read data expected
  } lsu_rsp_attr_t;

endpackage

`default_nettype wire

/* logic/lsu_access_if.sv */
//////////////////////////////////////////////////////////////////////
// decoded access from the decoder to the bus controller
// dec drives every field, ctrl only reads them
//////////////////////////////////////////////////////////////////////
`default_nettype none

interface lsu_access_if;
  import lsu_pkg::*;

  lsu_word_t addr;       // byte address
  logic      we;         // store when high
  lsu_be_t   be;         // lane enables
  lsu_word_t wdata;      // store data, already in its lanes
  lsu_size_e size;
  lsu_ext_e  ext;
  logic      req;        // core wants an access
  logic      misaligned; // access crosses a word, not issued

  modport dec (
    output addr, we, be, wdata, size, ext, req, misaligned
  );

  modport ctrl (
    input  addr, we, be, wdata, size, ext, req, misaligned
  );

endinterface

`default_nettype wire

/* logic/lsu_decode.sv */
//////////////////////////////////////////////////////////////////////
// access decoder of the load-store unit
// forms the address, checks alignment, makes byte enables and moves
// store data into its lanes; purely combinational
//////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_decode (
  input  logic                 req_i,        // access request from execute
  input  logic                 we_i,         // store when high
  input  lsu_pkg::lsu_size_e   size_i,       // word, half word or byte
  input  lsu_pkg::lsu_ext_e    ext_i,        // load extension mode
  input  lsu_pkg::lsu_word_t   operand_a_i,  // base
  input  lsu_pkg::lsu_word_t   operand_b_i,  // increment
  input  logic                 use_incr_i,   // a + b when set, a alone otherwise
  input  lsu_pkg::lsu_offset_t reg_offset_i, // byte position of data in the register
  input  lsu_pkg::lsu_word_t   wdata_i,      // store data as read from the register
  lsu_access_if.dec            acc
);
  import lsu_pkg::*;

  lsu_word_t   addr;
  lsu_offset_t addr_off;
  lsu_offset_t wdata_off; // lane distance from register to memory
  lsu_be_t     be;
  lsu_word_t   wdata_rot;
  logic        misaligned;

  //////////////////////////////////////////////////////////////////////
  // address and alignment
  //////////////////////////////////////////////////////////////////////

  assign addr     = use_incr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off = addr[1:0];

  // a word must sit on offset 0, a half word must not start at 3
  always_comb
  begin
    case (size_i)
      LSU_SIZE_WORD: misaligned = (addr_off != 2'b00);
      LSU_SIZE_HALF: misaligned = (addr_off == 2'b11);
      default:       misaligned = 1'b0; // bytes never cross a word
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  // lanes above bit 3 fall off, so a word at offset 2 gives 1100
  always_comb
  begin
    case (size_i)
      LSU_SIZE_WORD: be = 4'b1111 << addr_off; // offset up to lane 3
      LSU_SIZE_HALF: be = 4'b0011 << addr_off; // two lanes from offset
      default:       be = 4'b0001 << addr_off; // single lane
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // store data lanes
  //////////////////////////////////////////////////////////////////////

  // mod 4 wrap of the 2-bit subtraction is what we want here
  assign wdata_off = addr_off - reg_offset_i;

  // register byte k lands in memory lane k + wdata_off
  always_comb
  begin
    case (wdata_off)
      2'b00: wdata_rot = wdata_i;
      2'b01: wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'b10: wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      2'b11: wdata_rot = {wdata_i[7:0],  wdata_i[31:8]};
      default: wdata_rot = wdata_i;
    endcase
  end

  // towards the bus controller
  assign acc.addr       = addr;
  assign acc.we         = we_i;
  assign acc.be         = be;
  assign acc.wdata      = wdata_rot;
  assign acc.size       = size_i;
  assign acc.ext        = ext_i;
  assign acc.req        = req_i;
  assign acc.misaligned = req_i && misaligned; // only meaningful with a request

endmodule

`default_nettype wire

/* logic/lsu_bus_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// data memory bus controller, one access outstanding
// request is held until grant, read-valid closes the access and a
// new request may go out in that same cycle
//////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_bus_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  lsu_access_if.ctrl             acc,
  output logic                   ready_o,      // core request done this cycle
  output logic                   misaligned_o, // request refused, not issued
  output logic                   data_req_o,
  output logic                   data_we_o,
  output lsu_pkg::lsu_word_t     data_addr_o,
  output lsu_pkg::lsu_be_t       data_be_o,
  output lsu_pkg::lsu_word_t     data_wdata_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output lsu_pkg::lsu_rsp_attr_t attr_o        // attributes for the aligner
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT_RVALID
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   can_issue; // bus free now or freed by this read-valid
  logic   granted;

  //////////////////////////////////////////////////////////////////////
  // request and handshake
  //////////////////////////////////////////////////////////////////////

  assign can_issue = (state_q == ST_IDLE) || data_rvalid_i;

  assign data_req_o   = can_issue && acc.req && !acc.misaligned;
  assign misaligned_o = can_issue && acc.req && acc.misaligned;
  assign granted      = data_req_o && data_gnt_i;
  assign ready_o      = granted || misaligned_o; // one pulse per core request

  // bus fields follow the decoder, the core keeps them steady
  assign data_addr_o  = acc.addr;
  assign data_we_o    = acc.we;
  assign data_be_o    = acc.be;
  assign data_wdata_o = acc.wdata;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
      begin
        if (granted)
          state_d = ST_WAIT_RVALID;
      end
      ST_WAIT_RVALID:
      begin
        if (data_rvalid_i)
          state_d = granted ? ST_WAIT_RVALID : ST_IDLE; // back to back or done
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // capture what the aligner needs when the memory takes the access
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      attr_o <= '0;
    else if (granted)
      attr_o <= '{size: acc.size, ext: acc.ext, offset: acc.addr[1:0], we: acc.we};
  end

endmodule

`default_nettype wire

/* logic/lsu_rdata_align.sv */
//////////////////////////////////////////////////////////////////////
// read data alignment and extension
// picks the lanes of the finished load, fills the upper bits and
// holds the last load result between read-valid cycles
//////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  lsu_pkg::lsu_rsp_attr_t attr_i,        // captured at grant
  input  logic                   data_rvalid_i,
  input  lsu_pkg::lsu_word_t     data_rdata_i,
  output lsu_pkg::lsu_word_t     rdata_o,       // load result to the core
  output logic                   rdata_valid_o  // high in read-valid of a load
);
  import lsu_pkg::*;

  logic [15:0] half_sel;
  logic [7:0]  byte_sel;
  logic        fill_h;    // upper bit value for half words
  logic        fill_b;    // and for bytes
  lsu_word_t   rdata_ext;
  lsu_word_t   rdata_q;   // last load result

  // value of the bits above the loaded data
  function automatic logic ext_fill(lsu_ext_e mode, logic msb);
    case (mode)
      LSU_EXT_ZERO: ext_fill = 1'b0;
      LSU_EXT_ONE:  ext_fill = 1'b1;
      default:      ext_fill = msb; // both sign codes
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // lane selection
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (attr_i.offset)
      2'b00:   half_sel = data_rdata_i[15:0];
      2'b01:   half_sel = data_rdata_i[23:8];
      default: half_sel = data_rdata_i[31:16]; // offset 3 is never issued
    endcase
  end

  assign byte_sel = data_rdata_i[8*attr_i.offset +: 8];

  assign fill_h = ext_fill(attr_i.ext, half_sel[15]);
  assign fill_b = ext_fill(attr_i.ext, byte_sel[7]);

  always_comb
  begin
    case (attr_i.size)
      LSU_SIZE_WORD: rdata_ext = data_rdata_i;              // aligned word as is
      LSU_SIZE_HALF: rdata_ext = {{16{fill_h}}, half_sel};
      default:       rdata_ext = {{24{fill_b}}, byte_sel};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // result and hold register
  //////////////////////////////////////////////////////////////////////

  assign rdata_valid_o = data_rvalid_i && !attr_i.we; // stores return no data

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (rdata_valid_o)
      rdata_q <= rdata_ext;
  end

  // live value in the read-valid cycle, held value otherwise
  assign rdata_o = rdata_valid_o ? rdata_ext : rdata_q;

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
//////////////////////////////////////////////////////////////////////
// load-store unit top level
// core side takes one access at a time, memory side is a
// req/gnt/rvalid data bus with a single access outstanding
//////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // core side
  input  logic                 req_i,
  input  logic                 we_i,
  input  lsu_pkg::lsu_size_e   size_i,
  input  lsu_pkg::lsu_ext_e    ext_i,
  input  lsu_pkg::lsu_word_t   operand_a_i,
  input  lsu_pkg::lsu_word_t   operand_b_i,
  input  logic                 use_incr_i,
  input  lsu_pkg::lsu_offset_t reg_offset_i,
  input  lsu_pkg::lsu_word_t   wdata_i,
  output logic                 ready_o,
  output logic                 misaligned_o,
  output lsu_pkg::lsu_word_t   rdata_o,
  output logic                 rdata_valid_o,
  // data memory bus
  output logic                 data_req_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  output lsu_pkg::lsu_word_t   data_addr_o,
  output logic                 data_we_o,
  output lsu_pkg::lsu_be_t     data_be_o,
  output lsu_pkg::lsu_word_t   data_wdata_o,
  input  lsu_pkg::lsu_word_t   data_rdata_i
);
  import lsu_pkg::*;

  lsu_rsp_attr_t attr; // access in flight, controller to aligner

  lsu_access_if acc_if ();

  lsu_decode u_lsu_decode (
    .req_i        (req_i),
    .we_i         (we_i),
    .size_i       (size_i),
    .ext_i        (ext_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .use_incr_i   (use_incr_i),
    .reg_offset_i (reg_offset_i),
    .wdata_i      (wdata_i),
    .acc          (acc_if.dec)
  );

  lsu_bus_ctrl u_lsu_bus_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .acc           (acc_if.ctrl),
    .ready_o       (ready_o),
    .misaligned_o  (misaligned_o),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .attr_o        (attr)
  );

  lsu_rdata_align u_lsu_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .attr_i        (attr),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o)
  );

endmodule

`default_nettype wire

/* dv/lsu_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench of the load-store unit
// applies a table of stores, loads and misaligned accesses against a
// 16-word memory model with random grant and read-valid delays
//////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int unsigned NUM_ENTRIES    = 20;
  localparam int unsigned TIMEOUT_CYCLES = 20 * NUM_ENTRIES + 50;
  localparam logic [31:0] RAND_SEED      = 32'h00cfaf00;

  // one access with its hand-worked expectations
  typedef struct packed {
    logic        we;
    logic [1:0]  size;      // 0 word, 1 half, 2/3 byte
    logic [1:0]  ext;       // 0 zeros, 2 ones, 1/3 sign
    lsu_word_t   op_a;
    lsu_word_t   op_b;
    logic        use_incr;
    lsu_offset_t reg_off;
    lsu_word_t   wdata;
    lsu_word_t   exp_addr;
    lsu_be_t     exp_be;
    lsu_word_t   exp_wdata; // store data after lane rotation
    logic        exp_mis;
    lsu_word_t   exp_rdata; // extended load result
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        req_i;
  logic        we_i;
  lsu_size_e   size_i;
  lsu_ext_e    ext_i;
  lsu_word_t   operand_a_i;
  lsu_word_t   operand_b_i;
  logic        use_incr_i;
  lsu_offset_t reg_offset_i;
  lsu_word_t   wdata_i;
  logic        ready_o;
  logic        misaligned_o;
  lsu_word_t   rdata_o;
  logic        rdata_valid_o;
  logic        data_req_o;
  logic        data_gnt_i;
  logic        data_rvalid_i;
  lsu_word_t   data_addr_o;
  logic        data_we_o;
  lsu_be_t     data_be_o;
  lsu_word_t   data_wdata_o;
  lsu_word_t   data_rdata_i;

  entry_t      tbl [NUM_ENTRIES];
  lsu_word_t   mem [16];  // word index is addr[5:2]
  lsu_word_t   last_load; // what rdata_o must hold between loads

  lsu_top u_lsu_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // failure handling and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string what, input lsu_word_t got, input lsu_word_t exp);
    if (got !== exp)
    begin
      $display("ERR @%0t: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_be(input string what, input lsu_be_t got, input lsu_be_t exp);
    if (got !== exp)
    begin
      $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory model that grants after 0..3 request cycles and answers
  // each grant with one read-valid 1..4 cycles later
  //////////////////////////////////////////////////////////////////////

  initial
  begin : mem_model
    int unsigned gnt_cnt;
    int unsigned rv_cnt;
    logic        rv_pending;
    lsu_word_t   rd_word;
    void'($urandom(RAND_SEED));
    gnt_cnt    = $urandom % 4;
    rv_cnt     = 0;
    rv_pending = 1'b0;
    rd_word    = '0;
    for (int i = 0; i < 16; i++)
      mem[i] = (32'h0101_0101 * i) ^ 32'hc0c0_c0c0; // c0c0c0c0, c1c1c1c1 ...
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    forever
    begin
      @(posedge clk);
      if (data_rvalid_i)
        rv_pending = 1'b0;
      else if (rv_pending && rv_cnt != 0)
        rv_cnt = rv_cnt - 1;
      if (data_req_o && data_gnt_i)
      begin
        if (data_we_o)
        begin
          for (int b = 0; b < 4; b++)
            if (data_be_o[b])
              mem[data_addr_o[5:2]][8*b +: 8] = data_wdata_o[8*b +: 8];
        end
        else
          rd_word = mem[data_addr_o[5:2]];
        rv_pending = 1'b1;
        rv_cnt     = $urandom % 4;
        gnt_cnt    = $urandom % 4; // delay for the next request
      end
      else if (data_req_o && gnt_cnt != 0)
        gnt_cnt = gnt_cnt - 1;
      #1;
      data_gnt_i    = (gnt_cnt == 0);
      data_rvalid_i = rv_pending && (rv_cnt == 0);
      data_rdata_i  = data_rvalid_i ? rd_word : '0;
    end
  end

  initial
  begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("run hung: table not finished after %0d cycles", TIMEOUT_CYCLES);
    stop_with_failure();
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // drives one access, called on a rising edge
  task automatic run_entry(input entry_t e);
    logic done;
    done = 1'b0;
    #1;
    req_i        = 1'b1;
    we_i         = e.we;
    size_i       = lsu_size_e'(e.size);
    ext_i        = lsu_ext_e'(e.ext);
    operand_a_i  = e.op_a;
    operand_b_i  = e.op_b;
    use_incr_i   = e.use_incr;
    reg_offset_i = e.reg_off;
    wdata_i      = e.wdata;
    while (!done)
    begin
      @(posedge clk);
      check_flag("misaligned_o", misaligned_o, e.exp_mis);
      check_flag("rdata_valid_o", rdata_valid_o, 1'b0);
      if (e.exp_mis)
      begin
        check_flag("data_req_o", data_req_o, 1'b0); // never issued
        check_flag("ready_o", ready_o, 1'b1);
      end
      else
      begin
        // request and fields held until grant
        check_flag("data_req_o", data_req_o, 1'b1);
        check_word("data_addr_o", data_addr_o, e.exp_addr);
        check_be("data_be_o", data_be_o, e.exp_be);
        check_flag("data_we_o", data_we_o, e.we);
        check_flag("ready_o", ready_o, data_gnt_i); // done exactly at grant
        if (e.we)
          check_word("data_wdata_o", data_wdata_o, e.exp_wdata);
      end
      done = ready_o;
    end
    if (e.exp_mis)
      check_word("rdata_o held", rdata_o, last_load);
    else
    begin
      #1;
      req_i = 1'b0;
      done  = 1'b0;
      while (!done)
      begin
        @(posedge clk);
        check_flag("ready_o", ready_o, 1'b0);
        done = data_rvalid_i;
        check_flag("rdata_valid_o", rdata_valid_o, done && !e.we); // loads only
      end
      if (e.we)
        check_word("rdata_o held", rdata_o, last_load);
      else
      begin
        check_word("rdata_o", rdata_o, e.exp_rdata);
        last_load = e.exp_rdata;
      end
    end
  endtask

  initial
  begin
    // we size ext op_a op_b incr roff wdata | addr be rot_wdata mis rdata
    tbl[ 0] = '{1, 0, 0, 'h04, 'h00, 0, 0, 'h8899aabb, 'h04, 'hf, 'h8899aabb, 0, 'h0};
    tbl[ 1] = '{1, 1, 0, 'h08, 'h02, 1, 0, 'h0000f00d, 'h0a, 'hc, 'hf00d0000, 0, 'h0};
    tbl[ 2] = '{1, 2, 0, 'h08, 'h01, 1, 0, 'h00000081, 'h09, 'h2, 'h00008100, 0, 'h0};
    tbl[ 3] = '{1, 3, 0, 'h0b, 'h100, 0, 1, 'h00007f00, 'h0b, 'h8, 'h7f000000, 0, 'h0};
    tbl[ 4] = '{1, 1, 0, 'h0c, 'h01, 1, 2, 'hc3a50000, 'h0d, 'h6, 'h00c3a500, 0, 'h0};
    tbl[ 5] = '{0, 0, 0, 'h04, 'h00, 0, 0, 'h0, 'h04, 'hf, 'h0, 0, 'h8899aabb};
    tbl[ 6] = '{0, 2, 0, 'h08, 'h00, 0, 0, 'h0, 'h08, 'h1, 'h0, 0, 'h000000c2};
    tbl[ 7] = '{0, 2, 1, 'h09, 'h00, 0, 0, 'h0, 'h09, 'h2, 'h0, 0, 'hffffff81};
    tbl[ 8] = '{0, 2, 2, 'h04, 'h06, 1, 0, 'h0, 'h0a, 'h4, 'h0, 0, 'hffffff0d};
    tbl[ 9] = '{0, 3, 3, 'h0b, 'h00, 0, 0, 'h0, 'h0b, 'h8, 'h0, 0, 'h0000007f};
    tbl[10] = '{0, 1, 1, 'h08, 'h00, 0, 0, 'h0, 'h08, 'h3, 'h0, 0, 'hffff81c2};
    tbl[11] = '{0, 1, 0, 'h0d, 'h00, 0, 0, 'h0, 'h0d, 'h6, 'h0, 0, 'h0000c3a5};
    tbl[12] = '{0, 1, 2, 'h0a, 'h00, 0, 0, 'h0, 'h0a, 'hc, 'h0, 0, 'hffff7f0d};
    tbl[13] = '{0, 1, 3, 'h02, 'h04, 1, 0, 'h0, 'h06, 'hc, 'h0, 0, 'hffff8899};
    tbl[14] = '{0, 0, 0, 'h05, 'h00, 0, 0, 'h0, 'h05, 'h0, 'h0, 1, 'h0}; // word at 1
    tbl[15] = '{1, 1, 0, 'h0c, 'h03, 1, 0, 'h1234, 'h0f, 'h0, 'h0, 1, 'h0}; // half at 3
    tbl[16] = '{1, 0, 0, 'h0e, 'h00, 0, 0, 'h5555, 'h0e, 'h0, 'h0, 1, 'h0};
    tbl[17] = '{1, 2, 0, 'h3c, 'h00, 0, 0, 'h00000055, 'h3c, 'h1, 'h00000055, 0, 'h0};
    tbl[18] = '{1, 0, 0, 'h08, 'h08, 1, 3, 'h11223344, 'h10, 'hf, 'h22334411, 0, 'h0};
    tbl[19] = '{0, 0, 1, 'h10, 'h00, 0, 0, 'h0, 'h10, 'hf, 'h0, 0, 'h22334411};

    last_load    = '0;
    rst_n        = 1'b0;
    req_i        = 1'b0;
    we_i         = 1'b0;
    size_i       = LSU_SIZE_WORD;
    ext_i        = LSU_EXT_ZERO;
    operand_a_i  = '0;
    operand_b_i  = '0;
    use_incr_i   = 1'b0;
    reg_offset_i = '0;
    wdata_i      = '0;
    repeat (4) @(posedge clk);
    // outputs quiet under reset
    check_flag("data_req_o", data_req_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b0);
    check_flag("misaligned_o", misaligned_o, 1'b0);
    check_flag("rdata_valid_o", rdata_valid_o, 1'b0);
    check_word("rdata_o", rdata_o, '0);
    #1 rst_n = 1'b1;
    @(posedge clk);

    for (int i = 0; i < NUM_ENTRIES; i++)
      run_entry(tbl[i]);

    // unwritten lanes of the memory keep their fill
    check_word("mem[1]", mem[1], 32'h8899aabb);
    check_word("mem[2]", mem[2], 32'h7f0d81c2);
    check_word("mem[3]", mem[3], 32'hc3c3a5c3);
    check_word("mem[4]", mem[4], 32'h22334411);
    check_word("mem[15]", mem[15], 32'hcfcfcf55);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/lsu_pkg.sv
logic/lsu_access_if.sv
logic/lsu_decode.sv
logic/lsu_bus_ctrl.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
dv/lsu_tb.sv
